// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= tb_lsu_top
RTL_TOP   ?= lsu_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing -j 0
LINTFLAGS ?= --timing
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	$(SIM)

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem #(
    parameter logic [31:0] SEED = 32'd1
) (
    input  logic                clk,
    input  logic                rst,
    input  lsu_pkg::addr_t      araddr,
    input  logic                arvalid,
    output logic                arready,
    output lsu_pkg::data_t      rdata,
    output lsu_pkg::resp_t      rresp,
    output logic                rvalid,
    input  logic                rready,
    input  lsu_pkg::addr_t      awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  lsu_pkg::data_t      wdata,
    input  lsu_pkg::strb_t      wstrb,
    input  logic                wvalid,
    output logic                wready,
    output lsu_pkg::resp_t      bresp,
    output logic                bvalid,
    input  logic                bready
);

    lsu_pkg::data_t mem [0:255];
    lsu_pkg::addr_t aw_addr;
    lsu_pkg::data_t w_data;
    lsu_pkg::strb_t w_strb;
    logic           aw_got;
    logic           w_got;
    logic [1:0]     ar_wait;
    logic [1:0]     aw_wait;
    logic [1:0]     w_wait;
    logic [31:0]    rng;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic lsu_pkg::data_t initial_word(input lsu_pkg::addr_t a);
        return a * 32'h9E37_79B1 + 32'h0F1E_2D3C;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= lsu_pkg::RESP_OKAY;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= lsu_pkg::RESP_OKAY;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_wait <= 2'd0;
            aw_wait <= 2'd0;
            w_wait  <= 2'd0;
            rng     <= SEED;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= initial_word(i * 4);
            end
        end else begin
            rng <= lcg_step(rng);

            // read channel
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                arready <= 1'b0;
                ar_wait <= rng[17:16];
                rvalid  <= 1'b1;
                if (araddr[31:28] == 4'hF) begin
                    rdata <= 32'hDEAD_BEEF;
                    rresp <= lsu_pkg::RESP_SLVERR;
                end else begin
                    rdata <= mem[araddr[9:2]];
                    rresp <= lsu_pkg::RESP_OKAY;
                end
            end else if (arvalid && !rvalid) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end

            // write address and data are taken independently
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_wait <= rng[20:19];
                aw_addr <= awaddr;
                aw_got  <= 1'b1;
            end else if (awvalid && !aw_got) begin
                if (aw_wait == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                w_wait <= rng[23:22];
                w_data <= wdata;
                w_strb <= wstrb;
                w_got  <= 1'b1;
            end else if (wvalid && !w_got) begin
                if (w_wait == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 2'd1;
                end
            end

            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (aw_got && w_got && !bvalid) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
                if (aw_addr[31:28] == 4'hF) begin
                    bresp <= lsu_pkg::RESP_SLVERR;
                end else begin
                    bresp <= lsu_pkg::RESP_OKAY;
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb[b]) begin
                            mem[aw_addr[9:2]][8*b +: 8] <= w_data[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

// File: verif/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top;

    localparam int          NUM_OPS        = 400;
    localparam int          TIMEOUT_CYCLES = NUM_OPS * 24 + 100;
    localparam logic [31:0] SEED           = 32'd88951;

    logic               clk;
    logic               rst;
    logic               req_valid;
    logic               req_ready;
    logic               req_store;
    lsu_pkg::mem_size_t req_size;
    logic               req_signed;
    lsu_pkg::addr_t     req_addr;
    lsu_pkg::data_t     req_wdata;
    lsu_pkg::reg_idx_t  req_rd;
    logic               resp_valid;
    logic               resp_ready;
    logic               resp_store;
    lsu_pkg::reg_idx_t  resp_rd;
    lsu_pkg::data_t     resp_data;
    logic               resp_fault;
    lsu_pkg::addr_t     araddr;
    logic               arvalid;
    logic               arready;
    lsu_pkg::data_t     rdata;
    lsu_pkg::resp_t     rresp;
    logic               rvalid;
    logic               rready;
    lsu_pkg::addr_t     awaddr;
    logic               awvalid;
    logic               awready;
    lsu_pkg::data_t     wdata;
    lsu_pkg::strb_t     wstrb;
    logic               wvalid;
    logic               wready;
    lsu_pkg::resp_t     bresp;
    logic               bvalid;
    logic               bready;

    // reference memory and the responses still owed by the DUT
    lsu_pkg::data_t    model_mem [0:255];
    lsu_pkg::data_t    exp_data_q[$];
    logic              exp_fault_q[$];
    lsu_pkg::reg_idx_t exp_rd_q[$];
    logic              exp_store_q[$];

    logic [31:0] stim_state;
    logic [31:0] ready_state;
    int          cycles = 0;
    int          resp_count = 0;
    int          bus_count = 0;
    int          bus_expected = 0;

    lsu_top i_lsu_top (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_store  (req_store),
        .req_size   (req_size),
        .req_signed (req_signed),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_rd     (req_rd),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_store (resp_store),
        .resp_rd    (resp_rd),
        .resp_data  (resp_data),
        .resp_fault (resp_fault),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready)
    );

    // each random stream starts from the seed plus its own stream number
    tb_axi_mem #(.SEED(SEED + 32'd3)) i_axi_mem (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic lsu_pkg::data_t initial_word(input lsu_pkg::addr_t a);
        return a * 32'h9E37_79B1 + 32'h0F1E_2D3C;
    endfunction

    // value below limit from the stimulus stream
    function automatic int draw(input int limit);
        stim_state = lcg_step(stim_state);
        return int'(stim_state >> 8) % limit;
    endfunction

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input lsu_pkg::data_t act, input lsu_pkg::data_t exp);
        if (act !== exp) begin
            $display("ERR %0t resp_data got %h expected %h", $time, act, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_fault(input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERR %0t resp_fault got %b expected %b", $time, act, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_rd(input lsu_pkg::reg_idx_t act, input lsu_pkg::reg_idx_t exp);
        if (act !== exp) begin
            $display("ERR %0t resp_rd got %0d expected %0d", $time, act, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_store(input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERR %0t resp_store got %b expected %b", $time, act, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_level(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, act, exp);
            stop_with_failure();
        end
    endtask

    // reference model run at the edge where a request is accepted
    task automatic accept_request(input logic store, input lsu_pkg::mem_size_t size,
            input logic sgn, input lsu_pkg::addr_t addr, input lsu_pkg::data_t wd,
            input lsu_pkg::reg_idx_t rd);
        int             lane;
        int             nbytes;
        int             b;
        logic           bad_align;
        logic           err;
        lsu_pkg::data_t word;
        lsu_pkg::data_t value;
        lane      = int'(addr[1:0]);
        nbytes    = 1 << int'(size);
        bad_align = (lane % nbytes) != 0;
        err       = (addr[31:28] == 4'hF);
        word      = model_mem[addr[9:2]];
        value     = '0;
        if (!bad_align) begin
            bus_expected++;
        end
        if (!bad_align && !err) begin
            if (store) begin
                for (b = 0; b < nbytes; b++) begin
                    word[8*(lane+b) +: 8] = wd[8*b +: 8];
                end
                model_mem[addr[9:2]] = word;
            end else begin
                for (b = 0; b < nbytes; b++) begin
                    value[8*b +: 8] = word[8*(lane+b) +: 8];
                end
                for (b = nbytes; b < 4; b++) begin
                    value[8*b +: 8] = {8{sgn & value[8*nbytes-1]}};
                end
            end
        end
        exp_data_q.push_back(value);
        exp_fault_q.push_back(bad_align || err);
        exp_rd_q.push_back(rd);
        exp_store_q.push_back(store);
    endtask

    initial begin
        logic               st;
        lsu_pkg::mem_size_t sz;
        lsu_pkg::addr_t     addr;
        int                 off;
        clk         = 1'b0;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_store   = 1'b0;
        req_size    = lsu_pkg::SIZE_WORD;
        req_signed  = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_rd      = '0;
        resp_ready  = 1'b0;
        stim_state  = SEED;
        ready_state = SEED + 32'd2;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = initial_word(lsu_pkg::addr_t'(i * 4));
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_level("req_ready", req_ready, 1'b1);
        check_level("resp_valid", resp_valid, 1'b0);
        check_level("arvalid", arvalid, 1'b0);
        check_level("awvalid", awvalid, 1'b0);
        check_level("wvalid", wvalid, 1'b0);
        check_level("rready", rready, 1'b0);
        check_level("bready", bready, 1'b0);
        @(posedge clk);

        for (int n = 0; n < NUM_OPS; n++) begin
            st = (draw(2) == 1);
            sz = lsu_pkg::mem_size_t'(draw(3));
            // a 64-word window so that loads often meet earlier stores
            addr = {24'h0, 6'(draw(64)), 2'b00};
            if (draw(10) == 0) begin
                addr[31:28] = 4'hF;
            end
            if (draw(100) < 22) begin
                off = (sz == lsu_pkg::SIZE_HALF) ? 1 + 2 * draw(2) : 1 + draw(3);
            end else begin
                off = draw(4 >> int'(sz)) << int'(sz);
            end
            addr[1:0] = 2'(off);
            req_valid  <= 1'b1;
            req_store  <= st;
            req_size   <= sz;
            req_signed <= (draw(2) == 1);
            req_addr   <= addr;
            req_wdata  <= {16'(draw(65536)), 16'(draw(65536))};
            req_rd     <= lsu_pkg::reg_idx_t'(draw(32));
            @(posedge clk);
            while (!req_ready) begin
                @(posedge clk);
            end
            accept_request(req_store, req_size, req_signed, req_addr, req_wdata, req_rd);
            if (draw(4) == 0) begin
                req_valid <= 1'b0;
                @(posedge clk);
            end
        end
        req_valid <= 1'b0;

        while (resp_count < NUM_OPS) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (exp_data_q.size() == 0 && resp_count == NUM_OPS && bus_count == bus_expected) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("%0d responses and %0d bus transfers seen, %0d bus transfers expected",
                     resp_count, bus_count, bus_expected);
            stop_with_failure();
        end
    end

    // writeback side with random back-pressure
    always @(posedge clk) begin
        if (rst) begin
            resp_ready <= 1'b0;
        end else begin
            if (resp_valid && resp_ready) begin
                if (exp_data_q.size() == 0) begin
                    $display("a response arrived with no request outstanding");
                    stop_with_failure();
                end else begin
                    check_store(resp_store, exp_store_q.pop_front());
                    check_rd(resp_rd, exp_rd_q.pop_front());
                    check_fault(resp_fault, exp_fault_q.pop_front());
                    check_data(resp_data, exp_data_q.pop_front());
                    resp_count <= resp_count + 1;
                end
            end
            ready_state = lcg_step(ready_state);
            resp_ready <= (ready_state[28:27] != 2'b00);
        end
    end

    // misaligned requests must never reach the bus
    always @(posedge clk) begin
        if (arvalid && arready) begin
            bus_count <= bus_count + 1;
        end else if (awvalid && awready) begin
            bus_count <= bus_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d responses received",
                     cycles, resp_count, NUM_OPS);
            stop_with_failure();
        end
    end

endmodule

// File: verilog/lsu_bus_master.sv
`timescale 1ns/1ps

module lsu_bus_master (
    input  logic                clk,
    input  logic                rst,
    input  logic                op_valid,
    output logic                op_ready,
    input  logic                op_store,
    input  lsu_pkg::mem_size_t  op_size,
    input  logic                op_signed,
    input  lsu_pkg::addr_t      op_addr,
    input  lsu_pkg::data_t      op_wdata,
    input  lsu_pkg::strb_t      op_strb,
    input  lsu_pkg::lane_t      op_lane,
    input  logic                op_misaligned,
    input  lsu_pkg::reg_idx_t   op_rd,
    output logic                done_valid,
    input  logic                done_ready,
    output logic                done_store,
    output lsu_pkg::mem_size_t  done_size,
    output logic                done_signed,
    output lsu_pkg::lane_t      done_lane,
    output lsu_pkg::data_t      done_raw,
    output logic                done_fault,
    output lsu_pkg::reg_idx_t   done_rd,
    output lsu_pkg::addr_t      araddr,
    output logic                arvalid,
    input  logic                arready,
    input  lsu_pkg::data_t      rdata,
    input  lsu_pkg::resp_t      rresp,
    input  logic                rvalid,
    output logic                rready,
    output lsu_pkg::addr_t      awaddr,
    output logic                awvalid,
    input  logic                awready,
    output lsu_pkg::data_t      wdata,
    output lsu_pkg::strb_t      wstrb,
    output logic                wvalid,
    input  logic                wready,
    input  lsu_pkg::resp_t      bresp,
    input  logic                bvalid,
    output logic                bready
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_ADDR,
        ST_RD_DATA,
        ST_WR_REQ,
        ST_WR_RESP,
        ST_DONE
    } state_t;

    state_t state;
    logic   aw_done;
    logic   w_done;

    assign op_ready   = (state == ST_IDLE);
    assign done_valid = (state == ST_DONE);

    // a channel counts as done once its valid has dropped or handshakes now
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (op_valid) begin
                        if (op_misaligned) begin
                            state <= ST_DONE;
                        end else if (op_store) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= ST_WR_REQ;
                        end else begin
                            arvalid <= 1'b1;
                            state   <= ST_RD_ADDR;
                        end
                    end
                end
                ST_RD_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= ST_RD_DATA;
                    end
                end
                ST_RD_DATA: begin
                    if (rvalid) begin
                        rready <= 1'b0;
                        state  <= ST_DONE;
                    end
                end
                ST_WR_REQ: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        bready <= 1'b1;
                        state  <= ST_WR_RESP;
                    end
                end
                ST_WR_RESP: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        state  <= ST_DONE;
                    end
                end
                default: begin
                    if (done_ready) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_ready) begin
            araddr      <= op_addr;
            awaddr      <= op_addr;
            wdata       <= op_wdata;
            wstrb       <= op_strb;
            done_store  <= op_store;
            done_size   <= op_size;
            done_signed <= op_signed;
            done_lane   <= op_lane;
            done_rd     <= op_rd;
            done_raw    <= '0;
            // misaligned ops never reach the bus
            done_fault  <= op_misaligned;
        end
        if (rvalid && rready) begin
            done_raw   <= rdata;
            done_fault <= (rresp != lsu_pkg::RESP_OKAY);
        end
        if (bvalid && bready) begin
            done_fault <= (bresp != lsu_pkg::RESP_OKAY);
        end
    end

endmodule

// File: verilog/lsu_load_format.sv
`timescale 1ns/1ps

module lsu_load_format (
    input  logic                clk,
    input  logic                rst,
    input  logic                done_valid,
    output logic                done_ready,
    input  logic                done_store,
    input  lsu_pkg::mem_size_t  done_size,
    input  logic                done_signed,
    input  lsu_pkg::lane_t      done_lane,
    input  lsu_pkg::data_t      done_raw,
    input  logic                done_fault,
    input  lsu_pkg::reg_idx_t   done_rd,
    output logic                resp_valid,
    input  logic                resp_ready,
    output logic                resp_store,
    output lsu_pkg::reg_idx_t   resp_rd,
    output lsu_pkg::data_t      resp_data,
    output logic                resp_fault
);

    lsu_pkg::data_t shifted;
    lsu_pkg::data_t extended;

    // held result blocks the master until writeback takes it
    assign done_ready = !resp_valid || resp_ready;

    assign shifted = done_raw >> {done_lane, 3'b000};

    always_comb begin
        case (done_size)
            lsu_pkg::SIZE_BYTE:
                extended = {{24{done_signed & shifted[7]}}, shifted[7:0]};
            lsu_pkg::SIZE_HALF:
                extended = {{16{done_signed & shifted[15]}}, shifted[15:0]};
            default:
                extended = shifted;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (done_valid && done_ready) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (done_valid && done_ready) begin
            resp_store <= done_store;
            resp_rd    <= done_rd;
            resp_fault <= done_fault;
            resp_data  <= (done_store || done_fault) ? '0 : extended;
        end
    end

endmodule

// File: verilog/lsu_pkg.sv
package lsu_pkg;

    // byte address and register/bus data
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // one strobe bit per byte lane
    typedef logic [3:0] strb_t;

    // destination register index
    typedef logic [4:0] reg_idx_t;

    // byte offset within a 32-bit word
    typedef logic [1:0] lane_t;

    // access size coded like the low bits of AXI size
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    // AXI response codes
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

// File: verilog/lsu_req_stage.sv
`timescale 1ns/1ps

module lsu_req_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    output logic                req_ready,
    input  logic                req_store,
    input  lsu_pkg::mem_size_t  req_size,
    input  logic                req_signed,
    input  lsu_pkg::addr_t      req_addr,
    input  lsu_pkg::data_t      req_wdata,
    input  lsu_pkg::reg_idx_t   req_rd,
    output logic                op_valid,
    input  logic                op_ready,
    output logic                op_store,
    output lsu_pkg::mem_size_t  op_size,
    output logic                op_signed,
    output lsu_pkg::addr_t      op_addr,
    output lsu_pkg::data_t      op_wdata,
    output lsu_pkg::strb_t      op_strb,
    output lsu_pkg::lane_t      op_lane,
    output logic                op_misaligned,
    output lsu_pkg::reg_idx_t   op_rd
);

    lsu_pkg::lane_t lane;
    logic           misaligned;
    lsu_pkg::strb_t strb;

    // buffer is free when empty or draining this cycle
    assign req_ready = !op_valid || op_ready;

    assign lane = req_addr[1:0];

    always_comb begin
        case (req_size)
            lsu_pkg::SIZE_BYTE: begin
                misaligned = 1'b0;
                strb       = 4'b0001 << lane;
            end
            lsu_pkg::SIZE_HALF: begin
                misaligned = lane[0];
                strb       = 4'b0011 << lane;
            end
            default: begin
                misaligned = (lane != 2'd0);
                strb       = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (req_valid && req_ready) begin
            op_valid <= 1'b1;
        end else if (op_ready) begin
            op_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            op_store      <= req_store;
            op_size       <= req_size;
            op_signed     <= req_signed;
            op_addr       <= req_addr;
            // store data moves up to its byte lane
            op_wdata      <= req_wdata << {lane, 3'b000};
            op_strb       <= strb;
            op_lane       <= lane;
            op_misaligned <= misaligned;
            op_rd         <= req_rd;
        end
    end

endmodule

// File: verilog/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    output logic                req_ready,
    input  logic                req_store,
    input  lsu_pkg::mem_size_t  req_size,
    input  logic                req_signed,
    input  lsu_pkg::addr_t      req_addr,
    input  lsu_pkg::data_t      req_wdata,
    input  lsu_pkg::reg_idx_t   req_rd,
    output logic                resp_valid,
    input  logic                resp_ready,
    output logic                resp_store,
    output lsu_pkg::reg_idx_t   resp_rd,
    output lsu_pkg::data_t      resp_data,
    output logic                resp_fault,
    output lsu_pkg::addr_t      araddr,
    output logic                arvalid,
    input  logic                arready,
    input  lsu_pkg::data_t      rdata,
    input  lsu_pkg::resp_t      rresp,
    input  logic                rvalid,
    output logic                rready,
    output lsu_pkg::addr_t      awaddr,
    output logic                awvalid,
    input  logic                awready,
    output lsu_pkg::data_t      wdata,
    output lsu_pkg::strb_t      wstrb,
    output logic                wvalid,
    input  logic                wready,
    input  lsu_pkg::resp_t      bresp,
    input  logic                bvalid,
    output logic                bready
);

    // request buffer to bus master
    logic               op_valid;
    logic               op_ready;
    logic               op_store;
    lsu_pkg::mem_size_t op_size;
    logic               op_signed;
    lsu_pkg::addr_t     op_addr;
    lsu_pkg::data_t     op_wdata;
    lsu_pkg::strb_t     op_strb;
    lsu_pkg::lane_t     op_lane;
    logic               op_misaligned;
    lsu_pkg::reg_idx_t  op_rd;

    // bus master to load formatter
    logic               done_valid;
    logic               done_ready;
    logic               done_store;
    lsu_pkg::mem_size_t done_size;
    logic               done_signed;
    lsu_pkg::lane_t     done_lane;
    lsu_pkg::data_t     done_raw;
    logic               done_fault;
    lsu_pkg::reg_idx_t  done_rd;

    lsu_req_stage i_req_stage (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_store     (req_store),
        .req_size      (req_size),
        .req_signed    (req_signed),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_rd        (req_rd),
        .op_valid      (op_valid),
        .op_ready      (op_ready),
        .op_store      (op_store),
        .op_size       (op_size),
        .op_signed     (op_signed),
        .op_addr       (op_addr),
        .op_wdata      (op_wdata),
        .op_strb       (op_strb),
        .op_lane       (op_lane),
        .op_misaligned (op_misaligned),
        .op_rd         (op_rd)
    );

    lsu_bus_master i_bus_master (
        .clk           (clk),
        .rst           (rst),
        .op_valid      (op_valid),
        .op_ready      (op_ready),
        .op_store      (op_store),
        .op_size       (op_size),
        .op_signed     (op_signed),
        .op_addr       (op_addr),
        .op_wdata      (op_wdata),
        .op_strb       (op_strb),
        .op_lane       (op_lane),
        .op_misaligned (op_misaligned),
        .op_rd         (op_rd),
        .done_valid    (done_valid),
        .done_ready    (done_ready),
        .done_store    (done_store),
        .done_size     (done_size),
        .done_signed   (done_signed),
        .done_lane     (done_lane),
        .done_raw      (done_raw),
        .done_fault    (done_fault),
        .done_rd       (done_rd),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready)
    );

    lsu_load_format i_load_format (
        .clk         (clk),
        .rst         (rst),
        .done_valid  (done_valid),
        .done_ready  (done_ready),
        .done_store  (done_store),
        .done_size   (done_size),
        .done_signed (done_signed),
        .done_lane   (done_lane),
        .done_raw    (done_raw),
        .done_fault  (done_fault),
        .done_rd     (done_rd),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_store  (resp_store),
        .resp_rd     (resp_rd),
        .resp_data   (resp_data),
        .resp_fault  (resp_fault)
    );

endmodule

// File: vlog.f
verilog/lsu_pkg.sv
verilog/lsu_req_stage.sv
verilog/lsu_bus_master.sv
verilog/lsu_load_format.sv
verilog/lsu_top.sv
verif/tb_axi_mem.sv
verif/tb_lsu_top.sv
